// ==== src.f ====
+incdir+rtl
rtl/sb_pkg.sv
rtl/sb_store_ctrl.sv
rtl/sb_lane_packer.sv
rtl/sb_store_buffer.sv
rtl/sb_read_sequencer.sv
rtl/sb_byte_aligner.sv
rtl/sb_store_top.sv
verification/tb_sb_store.sv

// ==== Makefile ====
# Verilator build and run of the vector store buffer testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       := tb_sb_store
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_sb_store.sv ====
// Vector store buffer testbench
// Random lane batches, credit return with delays, assertion checks on the write stream
`default_nettype none
`include "sb_consts.svh"

module tb_sb_store
  import sb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LIMIT = 2000;           // Cycles allowed for any single wait

  logic                       clk = 1'b0;
  logic                       rstn;
  logic                       cfg_start;
  sew_e                       cfg_sew;
  logic [`SB_BATCH_W-1:0]     cfg_batches;
  logic [1:0]                 cfg_offset;
  logic                       lane_valid;
  logic [`SB_LANES*32-1:0]    lane_data;
  logic                       wr_valid;
  logic [31:0]                wr_data;
  logic [3:0]                 wr_strb;
  logic                       wr_last;
  logic                       wr_credit = 1'b0;
  logic                       busy;

  logic [7:0]   ref_bytes [256];         // Byte stream B of the current store
  logic [31:0]  lane_mem [64][4];        // Elements per batch and lane
  logic [1:0]   gap_tab [64];            // Credit return delays
  int           seed = 17;
  int           cur_off;
  int           nbytes;                  // Length of B
  int           exp_beats;
  int           beat_idx;                // Beats seen in this store
  int           lasts;                   // Final beats seen since reset
  int           outstanding = 0;         // Beats not yet credited back
  int           errors = 0;
  int           ntests = 0;
  int           nfail = 0;
  logic         timeout_hit;
  logic         hold_credits;            // Withhold credit returns
  logic         clr_cnt;
  logic [31:0]  exp_data;
  logic [3:0]   exp_strb;
  logic [1:0]   gap;
  logic [5:0]   gap_idx;

  sb_store_top u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_start   (cfg_start),
    .cfg_sew     (cfg_sew),
    .cfg_batches (cfg_batches),
    .cfg_offset  (cfg_offset),
    .lane_valid  (lane_valid),
    .lane_data   (lane_data),
    .wr_valid    (wr_valid),
    .wr_data     (wr_data),
    .wr_strb     (wr_strb),
    .wr_last     (wr_last),
    .wr_credit   (wr_credit),
    .busy        (busy)
  );

  always #50 clk = ~clk;                 // 100 ns period

  ////////////////////////////////////////////////////////////
  // Expected beat, byte p carries B[4j+p-offset]

  always_comb begin
    int idx;
    exp_data = '0;
    exp_strb = '0;
    for (int p = 0; p < 4; p++) begin
      idx = 4 * beat_idx + p - cur_off;
      if (idx >= 0 && idx < nbytes) begin
        exp_data[8*p +: 8] = ref_bytes[idx[7:0]];
        exp_strb[p]        = 1'b1;
      end
    end
  end

  // Beat and final-beat counters
  always @(posedge clk) begin
    if (!rstn || clr_cnt) begin
      beat_idx <= 0;
    end else if (wr_valid) begin
      beat_idx <= beat_idx + 1;
    end
    if (!rstn) begin
      lasts <= 0;
    end else if (wr_valid && wr_last) begin
      lasts <= lasts + 1;
    end
  end

  // Receiver side, one credit back per consumed beat after a random gap
  always @(posedge clk) begin
    int next_out;
    if (!rstn) begin
      outstanding <= 0;
      wr_credit   <= 1'b0;
      gap         <= 2'd0;
      gap_idx     <= 6'd0;
    end else begin
      next_out = outstanding + (wr_valid ? 1 : 0) - (wr_credit ? 1 : 0);
      outstanding <= next_out;
      wr_credit   <= 1'b0;
      if (!hold_credits && next_out > 0) begin
        if (gap == 2'd0) begin
          wr_credit <= 1'b1;
          gap       <= gap_tab[gap_idx];
          gap_idx   <= gap_idx + 6'd1;
        end else begin
          gap <= gap - 2'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks

  a_data: assert property (@(posedge clk) disable iff (!rstn)
    wr_valid |-> (wr_data == exp_data))
    else begin
      errors = errors + 1;
      $display("MISMATCH wr_data beat %0d expected %h got %h",
               $sampled(beat_idx), $sampled(exp_data), $sampled(wr_data));
    end

  a_strb: assert property (@(posedge clk) disable iff (!rstn)
    wr_valid |-> (wr_strb == exp_strb))
    else begin
      errors = errors + 1;
      $display("MISMATCH wr_strb beat %0d expected %h got %h",
               $sampled(beat_idx), $sampled(exp_strb), $sampled(wr_strb));
    end

  // Last flag only on the final beat
  a_last: assert property (@(posedge clk) disable iff (!rstn)
    wr_valid |-> (wr_last == (beat_idx == exp_beats - 1)))
    else begin
      errors = errors + 1;
      $display("MISMATCH wr_last beat %0d expected %h got %h", $sampled(beat_idx),
               $sampled(beat_idx == exp_beats - 1), $sampled(wr_last));
    end

  a_last_valid: assert property (@(posedge clk) disable iff (!rstn) wr_last |-> wr_valid)
    else begin
      errors = errors + 1;
      $display("wr_last was set without wr_valid");
    end

  a_no_extra: assert property (@(posedge clk) disable iff (!rstn)
    wr_valid |-> (beat_idx < exp_beats))
    else begin
      errors = errors + 1;
      $display("A beat arrived after the end of the store");
    end

  a_outstanding: assert property (@(posedge clk) disable iff (!rstn)
    outstanding <= `SB_CREDITS)
    else begin
      errors = errors + 1;
      $display("More than %0d beats were outstanding", `SB_CREDITS);
    end

  // No credit left means no beat
  a_stall: assert property (@(posedge clk) disable iff (!rstn)
    (hold_credits && outstanding == `SB_CREDITS) |-> !wr_valid)
    else begin
      errors = errors + 1;
      $display("wr_valid was set while all credits were spent");
    end

  a_reset_idle: assert property (@(posedge clk) $rose(rstn) |-> (!busy && !wr_valid && !wr_last))
    else begin
      errors = errors + 1;
      $display("DUT was not idle after reset");
    end

  // Busy drops the cycle after the final slot, before its beat shows
  a_busy_end: assert property (@(posedge clk) disable iff (!rstn) wr_last |-> !busy)
    else begin
      errors = errors + 1;
      $display("busy was still high at the final beat");
    end

  ////////////////////////////////////////////////////////////
  // Waits, each a loop with its own timeout

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (busy !== level && n < LIMIT);
    if (busy !== level) begin
      $display("Timeout while waiting for busy to become %0d", level);
      timeout_hit = 1'b1;
    end
  endtask

  task automatic wait_last(input int count0);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (lasts == count0 && n < LIMIT);
    if (lasts == count0) begin
      $display("Timeout while waiting for the final beat of the store");
      timeout_hit = 1'b1;
    end
  endtask

  task automatic wait_outstanding(input int level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (outstanding != level && n < LIMIT);
    if (outstanding != level) begin
      $display("Timeout while credits were withheld, outstanding beats never reached %0d",
               level);
      timeout_hit = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One store from config to final beat

  task automatic drive_store(input sew_e sew, input int batches, input int off,
                             input bit hold, input bit poke);
    int           esz;
    int           bi;
    int           lasts0;
    logic [31:0]  elem;
    logic [127:0] row;
    esz = (sew == SEW32) ? 4 : (sew == SEW16) ? 2 : 1;   // Element bytes
    wait_busy(1'b0);
    if (timeout_hit) return;
    // B in element-index order, little-endian inside each element
    for (int b = 0; b < batches; b++) begin
      for (int l = 0; l < 4; l++) begin
        elem = $random(seed);
        lane_mem[b][l] = elem;
        for (int i = 0; i < esz; i++) begin
          bi = (4 * b + l) * esz + i;
          ref_bytes[bi[7:0]] = elem[8*i +: 8];
        end
      end
    end
    cur_off   = off;
    nbytes    = batches * 4 * esz;
    exp_beats = nbytes / 4 + ((off != 0) ? 1 : 0);  // Unaligned adds a closing beat
    lasts0    = lasts;
    @(posedge clk);
    clr_cnt      <= 1'b1;
    hold_credits <= hold;
    @(posedge clk);
    clr_cnt     <= 1'b0;
    cfg_start   <= 1'b1;
    cfg_sew     <= sew;
    cfg_batches <= 7'(batches);
    cfg_offset  <= 2'(off);
    @(posedge clk);
    cfg_start <= 1'b0;
    wait_busy(1'b1);
    if (timeout_hit) return;
    for (int b = 0; b < batches; b++) begin
      if (($random(seed) & 3) == 0) begin
        @(posedge clk);
        lane_valid <= 1'b0;              // Idle cycle between batches
        cfg_start  <= 1'b0;
      end
      for (int l = 0; l < 4; l++) begin
        row[32*l +: 32] = lane_mem[b][l];
      end
      @(posedge clk);
      lane_valid <= 1'b1;
      lane_data  <= row;
      if (poke && b == 0) begin
        cfg_start   <= 1'b1;             // Start while busy, must be dropped
        cfg_sew     <= SEW8;
        cfg_batches <= 7'd5;
        cfg_offset  <= 2'd3;
      end else begin
        cfg_start <= 1'b0;
      end
    end
    @(posedge clk);
    lane_valid <= 1'b0;
    cfg_start  <= 1'b0;
    if (hold) begin
      wait_outstanding(`SB_CREDITS);
      if (timeout_hit) return;
      repeat (12) @(posedge clk);        // Stay stalled a while
      hold_credits <= 1'b0;
    end
    wait_last(lasts0);
    if (timeout_hit) return;
    wait_busy(1'b0);
  endtask

  task automatic run_store(input int tnum, input string name, input sew_e sew,
                           input int batches, input int off, input bit hold, input bit poke);
    int err0;
    if (timeout_hit) return;             // Earlier wait already gave up
    err0 = errors;
    drive_store(sew, batches, off, hold, poke);
    ntests++;
    if (timeout_hit) begin
      nfail++;
      $display("test %0d %s: timed out", tnum, name);
    end else if (errors != err0) begin
      nfail++;
      $display("test %0d %s: failed with %0d errors", tnum, name, errors - err0);
    end else begin
      $display("test %0d %s: passed, %0d beats", tnum, name, exp_beats);
    end
  endtask

  initial begin
    rstn         = 1'b0;
    cfg_start    = 1'b0;
    cfg_sew      = SEW8;
    cfg_batches  = '0;
    cfg_offset   = 2'd0;
    lane_valid   = 1'b0;
    lane_data    = '0;
    hold_credits = 1'b0;
    clr_cnt      = 1'b0;
    timeout_hit  = 1'b0;
    for (int i = 0; i < 64; i++) begin
      gap_tab[i] = 2'($random(seed));
    end
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    run_store(1, "sew32 aligned", SEW32, 8, 0, 1'b0, 1'b0);
    run_store(2, "sew16 aligned", SEW16, 10, 0, 1'b0, 1'b0);
    run_store(3, "sew8 aligned", SEW8, 12, 0, 1'b0, 1'b0);
    run_store(4, "sew16 offset 2", SEW16, 7, 2, 1'b0, 1'b0);
    run_store(5, "sew8 offset 3", SEW8, 9, 3, 1'b0, 1'b0);
    run_store(6, "sew32 credits withheld", SEW32, 16, 0, 1'b1, 1'b0);
    run_store(7, "sew16 start while busy", SEW16, 6, 2, 1'b0, 1'b1);
    run_store(8, "sew8 offset 1 full buffer", SEW8, 64, 1, 1'b0, 1'b0);
    $display("tests %0d, passed %0d, failed %0d, assertion errors %0d",
             ntests, ntests - nfail, nfail, errors);
    if (nfail == 0 && errors == 0 && !timeout_hit) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_sb_store

`default_nettype wire

// ==== rtl/sb_store_top.sv ====
// Vector store buffer top
// Control, packing, buffering, read sequencing and byte alignment in a line
`default_nettype none
`include "sb_consts.svh"

module sb_store_top
  import sb_pkg::*;
(
  input  wire                         clk,
  input  wire                         rstn,
  // Store config
  input  wire                         cfg_start,
  input  wire sew_e                   cfg_sew,
  input  wire [`SB_BATCH_W-1:0]       cfg_batches,
  input  wire [1:0]                   cfg_offset,
  // Lanes
  input  wire                         lane_valid,
  input  wire [`SB_LANES*32-1:0]      lane_data,
  // Write stream
  output logic                        wr_valid,
  output logic [31:0]                 wr_data,
  output logic [3:0]                  wr_strb,
  output logic                        wr_last,
  input  wire                         wr_credit,
  output logic                        busy
);

  sew_e                       sew;
  logic [1:0]                 offset;
  logic [`SB_WIDX_W-1:0]      total_words;
  logic                       needs_tail;
  logic                       store_active;
  logic                       done;

  sb_word_u [`SB_BANKS-1:0]   row_data;
  logic [`SB_BANKS-1:0]       row_wen;
  logic [`SB_ROW_W-1:0]       row_addr;
  logic [`SB_WIDX_W-1:0]      words_written;

  logic                       rd_en;
  logic [`SB_WIDX_W-1:0]      rd_idx;
  sb_word_u                   rd_word;
  logic                       rd_word_valid;
  logic                       tail_slot;
  logic                       slot_last;

  ////////////////////////////////////////////////////////////
  // Stages

  sb_store_ctrl u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_start    (cfg_start),
    .cfg_sew      (cfg_sew),
    .cfg_batches  (cfg_batches),
    .cfg_offset   (cfg_offset),
    .done         (done),
    .sew          (sew),
    .offset       (offset),
    .total_words  (total_words),
    .needs_tail   (needs_tail),
    .store_active (store_active),
    .busy         (busy)
  );

  sb_lane_packer u_packer (
    .clk           (clk),
    .rstn          (rstn),
    .store_active  (store_active),
    .sew           (sew),
    .lane_valid    (lane_valid),
    .lane_data     (lane_data),
    .row_data      (row_data),
    .row_wen       (row_wen),
    .row_addr      (row_addr),
    .words_written (words_written)
  );

  sb_store_buffer u_buffer (
    .clk           (clk),
    .row_data      (row_data),
    .row_wen       (row_wen),
    .row_addr      (row_addr),
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .rd_word       (rd_word),
    .rd_word_valid (rd_word_valid)
  );

  sb_read_sequencer u_seq (
    .clk           (clk),
    .rstn          (rstn),
    .store_active  (store_active),
    .total_words   (total_words),
    .needs_tail    (needs_tail),
    .words_written (words_written),
    .wr_credit     (wr_credit),
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .tail_slot     (tail_slot),
    .slot_last     (slot_last),
    .done          (done)
  );

  sb_byte_aligner u_align (
    .clk           (clk),
    .rstn          (rstn),
    .offset        (offset),
    .rd_word       (rd_word),
    .rd_word_valid (rd_word_valid),
    .tail_slot     (tail_slot),
    .slot_last     (slot_last),
    .wr_valid      (wr_valid),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .wr_last       (wr_last)
  );

endmodule : sb_store_top

`default_nettype wire

// ==== rtl/sb_byte_aligner.sv ====
// Byte aligner
// Shifts words up by the byte offset, carries the spill and forms strobes
`default_nettype none

module sb_byte_aligner
  import sb_pkg::*;
(
  input  wire           clk,
  input  wire           rstn,
  input  wire [1:0]     offset,
  input  wire sb_word_u rd_word,
  input  wire           rd_word_valid,
  input  wire           tail_slot,      // One cycle ahead of the read data
  input  wire           slot_last,      // One cycle ahead of the read data
  output logic          wr_valid,
  output logic [31:0]   wr_data,
  output logic [3:0]    wr_strb,
  output logic          wr_last
);

  sb_word_u     rot;        // Word rotated up by offset bytes
  sb_word_u     carry;      // Previous rotated word with its low bytes still due
  sb_word_u     beat_data;
  logic [3:0]   beat_strb;
  logic         tail_q;
  logic         last_q;
  logic         first;      // Next beat opens a store
  logic         beat;

  assign beat = rd_word_valid || tail_q;

  ////////////////////////////////////////////////////////////
  // Rotate and merge with carry

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rot.b8[p] = rd_word_valid ? rd_word.b8[2'(p) - offset] : 8'h00; // Tail has no data
      if (2'(p) >= offset) begin
        beat_data.b8[p] = rot.b8[p];
        beat_strb[p]    = rd_word_valid;
      end else begin
        beat_data.b8[p] = carry.b8[p];     // Spill from the word before
        beat_strb[p]    = !first;          // First beat masks the low bytes
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tail_q   <= 1'b0;
      last_q   <= 1'b0;
      wr_valid <= 1'b0;
      wr_last  <= 1'b0;
      first    <= 1'b1;
      carry    <= '0;
    end else begin
      tail_q   <= tail_slot;
      last_q   <= slot_last;
      wr_valid <= beat;
      wr_last  <= beat && last_q;
      if (beat) begin
        first <= last_q;                   // Rearm for the next store
        carry <= last_q ? '0 : rot;        // Empty carry after the last beat
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      wr_data <= beat_data.w32;
      wr_strb <= beat_strb;
    end
  end

endmodule : sb_byte_aligner

`default_nettype wire

// ==== rtl/sb_read_sequencer.sv ====
// Read sequencer
// Issues word reads then the closing tail slot, one per cycle, under credits
`default_nettype none
`include "sb_consts.svh"

module sb_read_sequencer (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         store_active,
  input  wire [`SB_WIDX_W-1:0]        total_words,
  input  wire                         needs_tail,
  input  wire [`SB_WIDX_W-1:0]        words_written,  // Words already readable
  input  wire                         wr_credit,      // One beat consumed downstream
  output logic                        rd_en,
  output logic [`SB_WIDX_W-1:0]       rd_idx,
  output logic                        tail_slot,
  output logic                        slot_last,
  output logic                        done
);

  logic [`SB_WIDX_W-1:0]  slot_idx;     // Slots issued so far in this store
  logic [`SB_WIDX_W-1:0]  total_slots;  // Words plus optional tail
  logic [`SB_CRED_W-1:0]  credits;
  logic                   is_word;      // Next slot reads a word
  logic                   word_ready;
  logic                   issue;

  ////////////////////////////////////////////////////////////
  // Slot issue

  assign total_slots = total_words + `SB_WIDX_W'(needs_tail);
  assign is_word     = (slot_idx < total_words);
  assign word_ready  = (slot_idx < words_written);  // Write has landed

  always_comb begin
    issue = store_active && (credits != '0) && (slot_idx < total_slots);
    if (is_word && !word_ready) begin
      issue = 1'b0;                                  // Wait for the lanes
    end
  end

  assign rd_en     = issue && is_word;
  assign tail_slot = issue && !is_word;  // Flushes the aligner carry
  assign rd_idx    = slot_idx;
  assign slot_last = issue && (slot_idx == total_slots - 1'b1);
  assign done      = slot_last;

  always_ff @(posedge clk) begin
    if (!rstn || !store_active) begin
      slot_idx <= '0;
    end else if (issue) begin
      slot_idx <= slot_idx + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit counter, one spent per slot

  always_ff @(posedge clk) begin
    if (!rstn) begin
      credits <= `SB_CREDITS;
    end else begin
      credits <= credits - `SB_CRED_W'(issue) + `SB_CRED_W'(wr_credit);
    end
  end

  // Extra returns push it over the limit, a wrap below zero lands there too
  a_credit_range: assert property (@(posedge clk) disable iff (!rstn)
    credits <= `SB_CREDITS);

endmodule : sb_read_sequencer

`default_nettype wire

// ==== rtl/sb_store_buffer.sv ====
// Store buffer
// Four word banks with per-bank write enables and one registered read port
`default_nettype none
`include "sb_consts.svh"

module sb_store_buffer
  import sb_pkg::*;
(
  input  wire                         clk,
  input  wire sb_word_u [`SB_BANKS-1:0] row_data,
  input  wire [`SB_BANKS-1:0]         row_wen,
  input  wire [`SB_ROW_W-1:0]         row_addr,
  input  wire                         rd_en,
  input  wire [`SB_WIDX_W-1:0]        rd_idx,   // Word index in stream order
  output sb_word_u                    rd_word,
  output logic                        rd_word_valid
);

  sb_word_u               mem [`SB_BANKS][`SB_DEPTH];
  logic [1:0]             rd_bank;
  logic [`SB_ROW_W-1:0]   rd_row;

  // Word k lives in bank k mod 4, row k / 4
  assign rd_bank = 2'(rd_idx % `SB_BANKS);
  assign rd_row  = `SB_ROW_W'(rd_idx / `SB_BANKS);

  always_ff @(posedge clk) begin
    for (int b = 0; b < `SB_BANKS; b++) begin
      if (row_wen[b]) begin
        mem[b][row_addr] <= row_data[b];
      end
    end
  end

  // One cycle read, valid follows the request
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= mem[rd_bank][rd_row];
    end
    rd_word_valid <= rd_en;
  end

endmodule : sb_store_buffer

`default_nettype wire

// ==== rtl/sb_lane_packer.sv ====
// Lane packer
// Packs each lane batch into 4, 2 or 1 words and rotates them onto the banks
`default_nettype none
`include "sb_consts.svh"

module sb_lane_packer
  import sb_pkg::*;
(
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         store_active,
  input  wire sew_e                   sew,
  input  wire                         lane_valid,
  input  wire [`SB_LANES*32-1:0]      lane_data,     // Lane l at bits 32*l
  output sb_word_u [`SB_BANKS-1:0]    row_data,
  output logic [`SB_BANKS-1:0]        row_wen,
  output logic [`SB_ROW_W-1:0]        row_addr,
  output logic [`SB_WIDX_W-1:0]       words_written
);

  sb_word_u [`SB_LANES-1:0]  pw;        // Packed words in stream order
  logic [2:0]                nwords;    // Words produced by this batch
  sb_word_u [`SB_BANKS-1:0]  bank_word; // Packed words after bank rotation
  logic [`SB_BANKS-1:0]      bank_hit;
  logic [1:0]                rel;       // Word number landing on a bank
  logic [`SB_WIDX_W-1:0]     wptr;      // Next word index to place

  ////////////////////////////////////////////////////////////
  // Narrow packing, element index order

  always_comb begin
    pw = '0;
    case (sew)
      SEW32: begin
        for (int l = 0; l < `SB_LANES; l++) begin
          pw[l].w32 = lane_data[32*l +: 32];
        end
        nwords = 3'd4;
      end
      SEW16: begin
        for (int l = 0; l < `SB_LANES; l++) begin
          pw[l/2].h16[l%2] = lane_data[32*l +: 16]; // Two lanes per word
        end
        nwords = 3'd2;
      end
      default: begin
        for (int l = 0; l < `SB_LANES; l++) begin
          pw[0].b8[l] = lane_data[32*l +: 8];       // All four lanes in one word
        end
        nwords = 3'd1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Bank rotation, bank = ptr mod 4 and row = ptr / 4

  always_comb begin
    rel = 2'd0;
    for (int b = 0; b < `SB_BANKS; b++) begin
      rel          = 2'(b) - wptr[1:0];
      bank_word[b] = pw[rel];
      bank_hit[b]  = ({1'b0, rel} < nwords);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || !store_active) begin
      wptr          <= '0;       // Fresh pointer for each store
      row_wen       <= '0;
      words_written <= '0;
    end else begin
      row_wen <= lane_valid ? bank_hit : '0;
      if (lane_valid) begin
        wptr <= wptr + `SB_WIDX_W'(nwords);
      end
      // Counts words as the buffer takes them
      words_written <= words_written + `SB_WIDX_W'($countones(row_wen));
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid) begin
      row_data <= bank_word;
      row_addr <= wptr[`SB_ROW_W+1:2];  // Same row for every word of a batch
    end
  end

  // Lanes only deliver while a store is open
  a_lane_in_store: assert property (@(posedge clk) disable iff (!rstn)
    lane_valid |-> store_active);

endmodule : sb_lane_packer

`default_nettype wire

// ==== rtl/sb_store_ctrl.sv ====
// Store control
// Latches the store config, holds busy and works out word and slot totals
`default_nettype none
`include "sb_consts.svh"

module sb_store_ctrl
  import sb_pkg::*;
(
  input  wire                     clk,
  input  wire                     rstn,
  input  wire                     cfg_start,    // One-cycle start pulse
  input  wire sew_e               cfg_sew,
  input  wire [`SB_BATCH_W-1:0]   cfg_batches,
  input  wire [1:0]               cfg_offset,   // Low address bits of the base
  input  wire                     done,         // Final slot issued
  output sew_e                    sew,
  output logic [1:0]              offset,
  output logic [`SB_WIDX_W-1:0]   total_words,
  output logic                    needs_tail,
  output logic                    store_active,
  output logic                    busy
);

  logic                     accept;     // Start seen while idle
  logic [`SB_BATCH_W+1:0]   words_calc; // Untruncated word count

  assign accept = cfg_start && !busy;

  // Words per batch: 4, 2 or 1
  always_comb begin
    case (cfg_sew)
      SEW32:   words_calc = {cfg_batches, 2'b00};
      SEW16:   words_calc = {1'b0, cfg_batches, 1'b0};
      default: words_calc = {2'b00, cfg_batches};
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy        <= 1'b0;
      sew         <= SEW8;
      offset      <= 2'd0;
      total_words <= '0;
      needs_tail  <= 1'b0;
    end else if (accept) begin
      busy        <= 1'b1;
      sew         <= cfg_sew;
      offset      <= cfg_offset;
      total_words <= words_calc[`SB_WIDX_W-1:0];
      needs_tail  <= (cfg_offset != 2'd0); // Unaligned store closes with one extra beat
    end else if (done) begin
      busy <= 1'b0;                          // Drops the cycle after the final slot
    end
  end

  assign store_active = busy;

  // Offset must sit on an element boundary
  a_offset_aligned: assert property (@(posedge clk) disable iff (!rstn)
    accept |-> ((cfg_sew == SEW32) ? (cfg_offset == 2'd0) :
                (cfg_sew == SEW16) ? !cfg_offset[0] : 1'b1));

  // One vector group has to fit the banks
  a_fits_buffer: assert property (@(posedge clk) disable iff (!rstn)
    accept |-> (words_calc <= `SB_WORDS));

endmodule : sb_store_ctrl

`default_nettype wire

// ==== rtl/sb_pkg.sv ====
// Vector store buffer types
// Element width code and the 32-bit buffer word with its sub-word views
`default_nettype none

package sb_pkg;

  // Element width, reference encoding
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // One buffer word, decoded whole, as half-words or as bytes
  typedef union packed {
    logic [31:0]     w32;
    logic [1:0][15:0] h16; // h16[0] is the low half
    logic [3:0][7:0]  b8;  // b8[0] is the lowest byte
  } sb_word_u;

endpackage : sb_pkg

`default_nettype wire

// ==== rtl/sb_consts.svh ====
// Vector store buffer constants
// Lane count, buffer geometry, credit budget and index widths
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// Lanes and banks
`define SB_LANES   4    // Vector lanes feeding the buffer
`define SB_BANKS   4    // One bank per lane

// Buffer geometry
`define SB_DEPTH   16   // Rows per bank
`define SB_ROW_W   4    // Row address width
`define SB_WORDS   64   // Total words held

// Counters
`define SB_WIDX_W  7    // Word index, counts up to and including SB_WORDS
`define SB_BATCH_W 7    // Batch count from the config
`define SB_CREDITS 4    // Sender credits after reset
`define SB_CRED_W  3    // Credit counter width

`endif
